// ==== Bender.yml ====
package:
  name: axi_wr

sources:
  - design/axi_wr_pkg.sv
  - design/axi_skid_buf.sv
  - design/axi_addr_gen.sv
  - design/axi_sub_wr.sv
  - design/wr_mem.sv
  - design/axi_wr_top.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/axi_wr_sva.sv
      - testbench/axi_wr_tb.sv

// ==== design/axi_addr_gen.sv ====
// Next beat address for FIXED, INCR and WRAP bursts
module axi_addr_gen import axi_wr_pkg::*; (
    input  logic [AXI_AW-1:0] i_addr,
    input  logic [2:0]        i_size,
    input  axi_burst_e        i_burst,
    input  logic [7:0]        i_len,
    output logic [AXI_AW-1:0] o_next_addr
);

    // Bytes moved per beat
    logic [AXI_AW-1:0] beat_bytes;
    // Low bits below the transfer size
    logic [AXI_AW-1:0] size_mask;
    // Size-aligned address plus one beat
    logic [AXI_AW-1:0] incr_addr;
    // Low bits inside the wrap window
    logic [AXI_AW-1:0] wrap_mask;
    // Start of the wrap window
    logic [AXI_AW-1:0] wrap_base;

    always_comb begin
        beat_bytes = AXI_AW'(1) << i_size;
        size_mask  = beat_bytes - 1'b1;
        incr_addr  = (i_addr & ~size_mask) + beat_bytes;

        // Window is size times beat count, len is 1, 3, 7 or 15 for legal WRAP
        wrap_mask  = (beat_bytes * (AXI_AW'(i_len) + 1'b1)) - 1'b1;
        wrap_base  = i_addr & ~wrap_mask;

        unique case (i_burst)
            AXI_BURST_INCR: begin
                o_next_addr = incr_addr;
            end
            AXI_BURST_WRAP: begin
                // Keep upper bits, roll the offset inside the window
                o_next_addr = wrap_base | (incr_addr & wrap_mask);
            end
            default: begin
                // FIXED and reserved stay put
                o_next_addr = i_addr;
            end
        endcase
    end

endmodule

// ==== design/axi_skid_buf.sv ====
// Valid/ready skid buffer with one spare entry and an optional output register
module axi_skid_buf #(
    parameter int DW     = 8,
    parameter bit OUTREG = 1'b0
) (
    input  logic          clk,
    input  logic          rst_n,
    // Upstream side
    input  logic          i_valid,
    output logic          o_ready,
    input  logic [DW-1:0] i_data,
    // Downstream side
    output logic          o_valid,
    input  logic          i_ready,
    output logic [DW-1:0] o_data
);

    // Spare entry, filled when downstream stalls
    logic          skd_valid;
    logic [DW-1:0] skd_data;

    // Ready comes straight from a flop
    assign o_ready = !skd_valid;

    // Spare entry tracks the input while empty
    // Its valid flag decides whether the copy counts
    always_ff @(posedge clk) begin
        if (o_ready) begin
            skd_data <= i_data;
        end
    end

    generate
        if (OUTREG) begin : g_outreg
            // ------------------------------
            // Registered output stage
            // ------------------------------
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    skd_valid <= 1'b0;
                    o_valid   <= 1'b0;
                end else if (!o_valid || i_ready) begin
                    // Output free, spare entry has priority over new input
                    o_valid   <= i_valid || skd_valid;
                    skd_valid <= 1'b0;
                end else if (i_valid && o_ready) begin
                    // Output stalled, park the new item
                    skd_valid <= 1'b1;
                end
            end

            always_ff @(posedge clk) begin
                if (!o_valid || i_ready) begin
                    o_data <= skd_valid ? skd_data : i_data;
                end
            end
        end else begin : g_pass
            // ------------------------------
            // Zero-latency output
            // ------------------------------
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    skd_valid <= 1'b0;
                end else if (i_ready) begin
                    skd_valid <= 1'b0;
                end else if (i_valid && o_ready) begin
                    // Input shown downstream but not taken
                    skd_valid <= 1'b1;
                end
            end

            assign o_valid = i_valid || skd_valid;
            assign o_data  = skd_valid ? skd_data : i_data;
        end
    endgenerate

endmodule

// ==== design/axi_sub_wr.sv ====
// AXI write subordinate turning bursts into component beats with one response each
module axi_sub_wr import axi_wr_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    // AW channel
    input  logic     i_aw_valid,
    output logic     o_aw_ready,
    input  aw_req_t  i_aw,

    // W channel
    input  logic     i_w_valid,
    output logic     o_w_ready,
    input  w_beat_t  i_w,

    // B channel
    output logic     o_b_valid,
    input  logic     i_b_ready,
    output b_rsp_t   o_b,

    // Component side
    output logic     o_comp_dv,
    output comp_wr_t o_comp,
    input  logic     i_hld,
    input  logic     i_err
);

    // ------------------------------
    // Signals
    // ------------------------------
    // Request out of the AW skid buffer
    logic              req_valid;
    logic              req_ready;
    aw_req_t           req;
    logic              aw_take;

    // Active burst context
    aw_req_t           txn_ctx;
    logic              txn_active;
    logic              txn_err;
    logic [AXI_AW-1:0] txn_addr_nxt;

    // W path
    logic              w_in_valid;
    logic              w_skd_ready;
    w_beat_t           w_beat;
    logic              beat_take;
    logic              final_beat;

    // Response path
    logic              rsp_ready;
    b_rsp_t            rsp;

    // ------------------------------
    // Address request
    // ------------------------------
    axi_skid_buf #(
        .DW     ($bits(aw_req_t)),
        .OUTREG (1'b0)
    ) u_aw_skd (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (i_aw_valid),
        .o_ready (o_aw_ready),
        .i_data  (i_aw),
        .o_valid (req_valid),
        .i_ready (req_ready),
        .o_data  (req)
    );

    // New burst only with a free response slot guaranteed
    // Back-to-back only if the B output is not already occupied
    assign req_ready = rsp_ready && (!txn_active || (final_beat && !o_b_valid));
    assign aw_take   = req_valid && req_ready;

    // Burst state and sticky error
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txn_active <= 1'b0;
            txn_err    <= 1'b0;
        end else if (aw_take) begin
            txn_active <= 1'b1;
            txn_err    <= 1'b0;
        end else if (beat_take) begin
            txn_err <= txn_err || i_err;
            if (w_beat.last) begin
                txn_active <= 1'b0;
            end
        end
    end

    // Context load on AW, address step on each taken beat
    always_ff @(posedge clk) begin
        if (aw_take) begin
            txn_ctx <= req;
        end else if (beat_take) begin
            txn_ctx.addr <= txn_addr_nxt;
        end
    end

    axi_addr_gen u_addr_gen (
        .i_addr      (txn_ctx.addr),
        .i_size      (txn_ctx.size),
        .i_burst     (txn_ctx.burst),
        .i_len       (txn_ctx.len),
        .o_next_addr (txn_addr_nxt)
    );

    // ------------------------------
    // Write data
    // ------------------------------
    // Data only flows while a burst is open
    assign w_in_valid = i_w_valid && txn_active;
    assign o_w_ready  = w_skd_ready && txn_active;

    axi_skid_buf #(
        .DW     ($bits(w_beat_t)),
        .OUTREG (1'b0)
    ) u_w_skd (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (w_in_valid),
        .o_ready (w_skd_ready),
        .i_data  (i_w),
        .o_valid (o_comp_dv),
        .i_ready (!i_hld),
        .o_data  (w_beat)
    );

    assign beat_take  = o_comp_dv && !i_hld;
    assign final_beat = beat_take && w_beat.last;

    // Component beat, byte address taken from the context
    always_comb begin
        o_comp.addr = txn_ctx.addr;
        o_comp.id   = txn_ctx.id;
        o_comp.data = w_beat.data;
        o_comp.strb = w_beat.strb;
        o_comp.size = txn_ctx.size;
        o_comp.last = w_beat.last;
    end

    // ------------------------------
    // Response
    // ------------------------------
    // Error of the final beat itself counts too
    always_comb begin
        rsp.resp = (txn_err || i_err) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
        rsp.id   = txn_ctx.id;
    end

    // Registered output, spare entry lets the next burst finish
    axi_skid_buf #(
        .DW     ($bits(b_rsp_t)),
        .OUTREG (1'b1)
    ) u_b_skd (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (final_beat),
        .o_ready (rsp_ready),
        .i_data  (rsp),
        .o_valid (o_b_valid),
        .i_ready (i_b_ready),
        .o_data  (o_b)
    );

endmodule

// ==== design/axi_wr_pkg.sv ====
// Shared widths, burst and response encodings, AXI channel and component beat structs
package axi_wr_pkg;

    // ------------------------------
    // Widths and sizes
    // ------------------------------
    // Byte address width on AW
    localparam int AXI_AW    = 16;
    // Data bus width and bytes per beat
    localparam int AXI_DW    = 32;
    localparam int AXI_BC    = 4;
    // Byte offset bits inside one data word
    localparam int AXI_OW    = $clog2(AXI_BC);
    // Transaction ID width
    localparam int AXI_IW    = 2;
    // Memory depth and word index width
    localparam int MEM_WORDS = 64;
    localparam int MEM_AW    = 6;

    // ------------------------------
    // Encodings
    // ------------------------------
    // AxBURST values
    typedef enum logic [1:0] {
        AXI_BURST_FIXED = 2'b00,
        AXI_BURST_INCR  = 2'b01,
        AXI_BURST_WRAP  = 2'b10,
        AXI_BURST_RSVD  = 2'b11
    } axi_burst_e;

    // BRESP values, EXOKAY and DECERR never produced here
    typedef enum logic [1:0] {
        AXI_RESP_OKAY   = 2'b00,
        AXI_RESP_EXOKAY = 2'b01,
        AXI_RESP_SLVERR = 2'b10,
        AXI_RESP_DECERR = 2'b11
    } axi_resp_e;

    // ------------------------------
    // Channel payloads
    // ------------------------------
    // Write address request
    typedef struct packed {
        logic [AXI_AW-1:0] addr;
        axi_burst_e        burst;
        logic [2:0]        size;
        logic [7:0]        len;
        logic [AXI_IW-1:0] id;
    } aw_req_t;

    // One write data beat
    typedef struct packed {
        logic [AXI_DW-1:0] data;
        logic [AXI_BC-1:0] strb;
        logic              last;
    } w_beat_t;

    // Write response
    typedef struct packed {
        axi_resp_e         resp;
        logic [AXI_IW-1:0] id;
    } b_rsp_t;

    // Beat handed to the memory component
    typedef struct packed {
        logic [AXI_AW-1:0] addr;
        logic [AXI_IW-1:0] id;
        logic [AXI_DW-1:0] data;
        logic [AXI_BC-1:0] strb;
        logic [2:0]        size;
        logic              last;
    } comp_wr_t;

endpackage

// ==== design/axi_wr_top.sv ====
// Top level joining the write subordinate and the word memory
module axi_wr_top import axi_wr_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,

    // AW channel
    input  logic              i_aw_valid,
    output logic              o_aw_ready,
    input  aw_req_t           i_aw,

    // W channel
    input  logic              i_w_valid,
    output logic              o_w_ready,
    input  w_beat_t           i_w,

    // B channel
    output logic              o_b_valid,
    input  logic              i_b_ready,
    output b_rsp_t            o_b,

    // Read port for observation
    input  logic              i_rd_en,
    input  logic [MEM_AW-1:0] i_rd_addr,
    output logic [AXI_DW-1:0] o_rd_data
);

    // Component link
    logic     comp_dv;
    comp_wr_t comp;
    logic     mem_hld;
    logic     mem_err;

    // ------------------------------
    // Write subordinate
    // ------------------------------
    axi_sub_wr u_sub_wr (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_aw_valid (i_aw_valid),
        .o_aw_ready (o_aw_ready),
        .i_aw       (i_aw),
        .i_w_valid  (i_w_valid),
        .o_w_ready  (o_w_ready),
        .i_w        (i_w),
        .o_b_valid  (o_b_valid),
        .i_b_ready  (i_b_ready),
        .o_b        (o_b),
        .o_comp_dv  (comp_dv),
        .o_comp     (comp),
        .i_hld      (mem_hld),
        .i_err      (mem_err)
    );

    // ------------------------------
    // Memory
    // ------------------------------
    wr_mem u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_comp_dv (comp_dv),
        .i_comp    (comp),
        .o_hld     (mem_hld),
        .o_err     (mem_err),
        .i_rd_en   (i_rd_en),
        .i_rd_addr (i_rd_addr),
        .o_rd_data (o_rd_data)
    );

endmodule

// ==== design/wr_mem.sv ====
// Word memory with byte-strobed write port, priority read port, hold and range error
module wr_mem import axi_wr_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,

    // Write beats from the subordinate
    input  logic              i_comp_dv,
    input  comp_wr_t          i_comp,
    output logic              o_hld,
    output logic              o_err,

    // Observation read port
    input  logic              i_rd_en,
    input  logic [MEM_AW-1:0] i_rd_addr,
    output logic [AXI_DW-1:0] o_rd_data
);

    // Storage
    logic [AXI_DW-1:0] mem [MEM_WORDS];

    logic [MEM_AW-1:0] wr_idx;
    logic              wr_oor;
    logic              wr_take;

    // Single port, a read wins and stalls the write
    assign o_hld = i_rd_en;

    // Word index from the byte address
    assign wr_idx  = i_comp.addr[AXI_OW +: MEM_AW];
    // Anything past the last byte is out of range
    assign wr_oor  = i_comp.addr >= AXI_AW'(MEM_WORDS * AXI_BC);
    assign wr_take = i_comp_dv && !o_hld;

    // Flag only on the beat actually taken
    assign o_err = wr_take && wr_oor;

    // ------------------------------
    // Write port
    // ------------------------------
    always_ff @(posedge clk) begin
        if (wr_take && !wr_oor) begin
            for (int b = 0; b < AXI_BC; b++) begin
                // Byte lanes as given by the strobe
                if (i_comp.strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= i_comp.data[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------
    // Read port
    // ------------------------------
    // Data one cycle after the request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_rd_data <= '0;
        end else if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

// ==== filelist.f ====
design/axi_wr_pkg.sv
design/axi_skid_buf.sv
design/axi_addr_gen.sv
design/axi_sub_wr.sv
design/wr_mem.sv
design/axi_wr_top.sv
testbench/tb_clk_gen.sv
testbench/axi_wr_sva.sv
testbench/axi_wr_tb.sv

// ==== testbench/axi_wr_sva.sv ====
// Concurrent checks on AXI handshake stability, response timing and component hold
module axi_wr_sva import axi_wr_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     i_aw_valid,
    input logic     i_aw_ready,
    input aw_req_t  i_aw,
    input logic     i_w_valid,
    input logic     i_w_ready,
    input w_beat_t  i_w,
    input logic     i_b_valid,
    input logic     i_b_ready,
    input b_rsp_t   i_b,
    input logic     i_comp_dv,
    input comp_wr_t i_comp,
    input logic     i_hld
);

    // Number of property failures so far
    int fail_cnt = 0;

    // ------------------------------
    // Channel stability
    // ------------------------------
    // Stalled AW request keeps valid and payload
    aw_hold_chk: assert property (@(posedge clk) disable iff (!rst_n)
        i_aw_valid && !i_aw_ready |=> i_aw_valid && $stable(i_aw))
        else begin
            $error("AW request dropped or changed while stalled");
            fail_cnt++;
        end

    // Stalled W beat keeps valid and payload
    w_hold_chk: assert property (@(posedge clk) disable iff (!rst_n)
        i_w_valid && !i_w_ready |=> i_w_valid && $stable(i_w))
        else begin
            $error("W beat dropped or changed while stalled");
            fail_cnt++;
        end

    // Response waits unchanged for i_b_ready
    b_hold_chk: assert property (@(posedge clk) disable iff (!rst_n)
        i_b_valid && !i_b_ready |=> i_b_valid && $stable(i_b))
        else begin
            $error("B response dropped or changed while stalled");
            fail_cnt++;
        end

    // ------------------------------
    // Response rules
    // ------------------------------
    // A fresh response follows a taken final beat
    b_rise_chk: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_b_valid) |-> $past(i_comp_dv && !i_hld && i_comp.last))
        else begin
            $error("B valid rose without a final beat");
            fail_cnt++;
        end

    // Beat under hold stays put until the memory takes it
    comp_hold_chk: assert property (@(posedge clk) disable iff (!rst_n)
        i_comp_dv && i_hld |=> i_comp_dv && $stable(i_comp))
        else begin
            $error("Component beat lost or changed under hold");
            fail_cnt++;
        end

endmodule

bind axi_sub_wr axi_wr_sva sva0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_aw_valid (i_aw_valid),
    .i_aw_ready (o_aw_ready),
    .i_aw       (i_aw),
    .i_w_valid  (i_w_valid),
    .i_w_ready  (o_w_ready),
    .i_w        (i_w),
    .i_b_valid  (o_b_valid),
    .i_b_ready  (i_b_ready),
    .i_b        (o_b),
    .i_comp_dv  (o_comp_dv),
    .i_comp     (o_comp),
    .i_hld      (i_hld)
);

// ==== testbench/axi_wr_tb.sv ====
// Table-driven testbench for the AXI write subsystem with reference memory and timeout
module axi_wr_tb import axi_wr_pkg::*; ();

    // One row of the stimulus table
    typedef struct packed {
        aw_req_t           aw;
        logic [AXI_DW-1:0] seed;
        logic [7:0]        coll;
        logic [7:0]        stall;
        axi_resp_e         exp;
    } test_t;

    logic              clk;
    logic              rst_n;
    logic              i_aw_valid;
    logic              o_aw_ready;
    aw_req_t           i_aw;
    logic              i_w_valid;
    logic              o_w_ready;
    w_beat_t           i_w;
    logic              o_b_valid;
    logic              i_b_ready;
    b_rsp_t            o_b;
    logic              i_rd_en;
    logic [MEM_AW-1:0] i_rd_addr;
    logic [AXI_DW-1:0] o_rd_data;

    // Table, per-test bookkeeping and reference memory
    test_t              tests [$];
    string              names [$];
    int                 err_cnt [$];
    logic [MEM_WORDS-1:0] touched [$];
    logic [AXI_DW-1:0]  ref_mem [MEM_WORDS];
    w_beat_t            beats_q [$];
    int                 exp_q [$];
    int                 pending_q [$];

    int issued      = 0;
    int rsp_cnt     = 0;
    int stall_left  = 0;
    int extra_err   = 0;
    int cycle_cnt   = 0;
    int cycle_limit = 0;

    tb_clk_gen clk_gen0 (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    axi_wr_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_aw_valid (i_aw_valid),
        .o_aw_ready (o_aw_ready),
        .i_aw       (i_aw),
        .i_w_valid  (i_w_valid),
        .o_w_ready  (o_w_ready),
        .i_w        (i_w),
        .o_b_valid  (o_b_valid),
        .i_b_ready  (i_b_ready),
        .o_b        (o_b),
        .i_rd_en    (i_rd_en),
        .i_rd_addr  (i_rd_addr),
        .o_rd_data  (o_rd_data)
    );

    // ------------------------------
    // Table and reference model
    // ------------------------------
    task automatic add_test(input string name, input logic [AXI_AW-1:0] addr,
                            input axi_burst_e burst, input logic [2:0] size,
                            input logic [7:0] len, input logic [AXI_IW-1:0] id,
                            input logic [AXI_DW-1:0] seed, input int coll,
                            input int stall, input axi_resp_e exp);
        test_t t;
        t.aw.addr  = addr;
        t.aw.burst = burst;
        t.aw.size  = size;
        t.aw.len   = len;
        t.aw.id    = id;
        t.seed     = seed;
        t.coll     = coll[7:0];
        t.stall    = stall[7:0];
        t.exp      = exp;
        tests.push_back(t);
        names.push_back(name);
        err_cnt.push_back(0);
        touched.push_back('0);
    endtask

    // FIXED stays, INCR steps from the aligned address, WRAP folds in its window
    function automatic logic [AXI_AW-1:0] step_addr(input aw_req_t aw,
                                                    input logic [AXI_AW-1:0] addr);
        int bytes;
        int aligned;
        int win;
        int base;
        int res;
        bytes   = 1 << aw.size;
        aligned = (int'(addr) / bytes) * bytes;
        res     = int'(addr);
        if (aw.burst == AXI_BURST_INCR) begin
            res = aligned + bytes;
        end else if (aw.burst == AXI_BURST_WRAP) begin
            win  = bytes * (int'(aw.len) + 1);
            base = (int'(addr) / win) * win;
            res  = base + (aligned + bytes - base) % win;
        end
        return res[AXI_AW-1:0];
    endfunction

    // Byte bursts strobe their own lane on even beats, odd beats carry no bytes
    function automatic logic [AXI_BC-1:0] beat_strb(input aw_req_t aw,
                                                    input logic [AXI_AW-1:0] addr,
                                                    input int beat);
        logic [AXI_BC-1:0] strb;
        strb = '1;
        if (aw.size == 3'd0) begin
            strb = beat[0] ? '0 : (AXI_BC'(1) << addr[AXI_OW-1:0]);
        end
        return strb;
    endfunction

    // Builds the beats of one burst and applies them to the model
    task automatic plan_burst(input int idx);
        aw_req_t              aw;
        logic [AXI_AW-1:0]    addr;
        w_beat_t              beat;
        logic [MEM_WORDS-1:0] mask;
        int                   word;
        aw   = tests[idx].aw;
        addr = aw.addr;
        mask = '0;
        beats_q.delete();
        for (int b = 0; b <= int'(aw.len); b++) begin
            beat.data = tests[idx].seed + b;
            beat.strb = beat_strb(aw, addr, b);
            beat.last = (b == int'(aw.len));
            beats_q.push_back(beat);
            // Out-of-range beats mark their aliased word, which must stay unchanged
            word       = int'(addr >> AXI_OW) % MEM_WORDS;
            mask[word] = 1'b1;
            if (int'(addr) < MEM_WORDS * AXI_BC) begin
                for (int l = 0; l < AXI_BC; l++) begin
                    if (beat.strb[l]) begin
                        ref_mem[word][8*l +: 8] = beat.data[8*l +: 8];
                    end
                end
            end
            addr = step_addr(aw, addr);
        end
        touched[idx] = mask;
    endtask

    function automatic int run_limit();
        int sum;
        sum = 0;
        foreach (tests[i]) begin
            sum += int'(tests[i].aw.len) + 1 + int'(tests[i].coll) + int'(tests[i].stall) + 10;
        end
        return sum * 4;
    endfunction

    // ------------------------------
    // Drivers, all on the falling edge
    // ------------------------------
    task automatic send_aw(input aw_req_t aw);
        @(negedge clk);
        i_aw_valid = 1'b1;
        i_aw       = aw;
        // Ready comes from flops, so it holds until the next rising edge
        while (!o_aw_ready) @(negedge clk);
        @(negedge clk);
        i_aw_valid = 1'b0;
    endtask

    task automatic send_w();
        w_beat_t beat;
        while (beats_q.size() > 0) begin
            beat      = beats_q.pop_front();
            i_w_valid = 1'b1;
            i_w       = beat;
            while (!o_w_ready) @(negedge clk);
            @(negedge clk);
        end
        i_w_valid = 1'b0;
    endtask

    // Reads that steal the memory port during a burst
    task automatic collide(input int n);
        int delay;
        delay = 2 + ($urandom % 2);
        if (n > 0) begin
            repeat (delay) @(negedge clk);
            repeat (n) begin
                i_rd_en   = 1'b1;
                i_rd_addr = MEM_AW'($urandom);
                @(negedge clk);
            end
            i_rd_en = 1'b0;
        end
    endtask

    task automatic read_word(input int w, output logic [AXI_DW-1:0] data);
        @(negedge clk);
        i_rd_en   = 1'b1;
        i_rd_addr = MEM_AW'(w);
        @(negedge clk);
        i_rd_en   = 1'b0;
        data      = o_rd_data;
    endtask

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_resp(input int idx, input b_rsp_t exp, input b_rsp_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: response expected resp %0d id %0d, actual resp %0d id %0d",
                     names[idx], exp.resp, exp.id, act.resp, act.id);
            err_cnt[idx] = err_cnt[idx] + 1;
        end
    endtask

    task automatic check_word(input int idx, input int w, input logic [AXI_DW-1:0] exp,
                              input logic [AXI_DW-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: word %0d expected %h, actual %h", names[idx], w, exp, act);
            err_cnt[idx] = err_cnt[idx] + 1;
        end
    endtask

    task automatic report_test(input int idx);
        if (err_cnt[idx] == 0) begin
            $display("%s: passed", names[idx]);
        end else begin
            $display("%s: failed with %0d errors", names[idx], err_cnt[idx]);
        end
    endtask

    // Waits for every outstanding response, then reads back what the finished tests touched
    task automatic flush_checks();
        int                idx;
        logic [AXI_DW-1:0] rd;
        while (rsp_cnt < issued) @(negedge clk);
        while (pending_q.size() > 0) begin
            idx = pending_q.pop_front();
            for (int w = 0; w < MEM_WORDS; w++) begin
                if (touched[idx][w]) begin
                    read_word(w, rd);
                    check_word(idx, w, ref_mem[w], rd);
                end
            end
            report_test(idx);
        end
    endtask

    // ------------------------------
    // Response collector
    // ------------------------------
    initial begin : b_collect
        logic   valid_s;
        b_rsp_t rsp_s;
        b_rsp_t exp_rsp;
        int     idx;
        i_b_ready = 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            // Stall budget counts down from the start of its test
            if (stall_left > 0) begin
                i_b_ready  = 1'b0;
                stall_left = stall_left - 1;
            end else begin
                i_b_ready = 1'b1;
            end
            valid_s = o_b_valid;
            rsp_s   = o_b;
            if (valid_s && i_b_ready) begin
                @(posedge clk);
                if (exp_q.size() == 0) begin
                    $display("Response with id %0d arrived with no burst outstanding", rsp_s.id);
                    extra_err++;
                end else begin
                    idx          = exp_q.pop_front();
                    exp_rsp.resp = tests[idx].exp;
                    exp_rsp.id   = tests[idx].aw.id;
                    check_resp(idx, exp_rsp, rsp_s);
                    rsp_cnt++;
                end
            end
        end
    end

    // Run limit from the table length
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
            $display("Something failed");
            $finish;
        end
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int total_err;
        int passed;
        void'($urandom(95));
        i_aw_valid = 1'b0;
        i_aw       = '0;
        i_w_valid  = 1'b0;
        i_w        = '0;
        i_rd_en    = 1'b0;
        i_rd_addr  = '0;

        // Name, addr, burst, size, len, id, then seed, collisions, B stalls, response
        add_test("incr4", 16'h00, AXI_BURST_INCR, 3'd2, 8'd3, 2'd1,
                 32'h1111_0000, 0, 0, AXI_RESP_OKAY);
        add_test("fixed", 16'h40, AXI_BURST_FIXED, 3'd2, 8'd3, 2'd2,
                 32'h2222_0000, 0, 0, AXI_RESP_OKAY);
        add_test("wrap4", 16'h58, AXI_BURST_WRAP, 3'd2, 8'd3, 2'd3,
                 32'h3333_0000, 0, 0, AXI_RESP_OKAY);
        add_test("byte_strb", 16'h04, AXI_BURST_INCR, 3'd0, 8'd3, 2'd0,
                 32'hC3D2_E1F0, 0, 0, AXI_RESP_OKAY);
        add_test("mem_end", 16'hF8, AXI_BURST_INCR, 3'd2, 8'd3, 2'd1,
                 32'h5555_0000, 0, 0, AXI_RESP_SLVERR);
        add_test("rd_clash", 16'h80, AXI_BURST_INCR, 3'd2, 8'd7, 2'd2,
                 32'h6666_0000, 5, 0, AXI_RESP_OKAY);
        add_test("bstall_a", 16'hA0, AXI_BURST_INCR, 3'd2, 8'd3, 2'd3,
                 32'h7777_0000, 0, 20, AXI_RESP_OKAY);
        add_test("bstall_b", 16'hC0, AXI_BURST_INCR, 3'd2, 8'd1, 2'd0,
                 32'h8888_0000, 2, 0, AXI_RESP_OKAY);

        cycle_limit = run_limit();
        wait (rst_n === 1'b1);

        foreach (tests[i]) begin
            @(posedge clk);
            plan_burst(i);
            stall_left = stall_left + int'(tests[i].stall);
            exp_q.push_back(i);
            issued++;
            fork
                begin
                    send_aw(tests[i].aw);
                    send_w();
                end
                collide(int'(tests[i].coll));
            join
            pending_q.push_back(i);
            // A stalled response stays queued while the next burst runs
            if (tests[i].stall == 0) begin
                flush_checks();
            end
        end
        flush_checks();

        // Protocol property failures count as errors too
        total_err = extra_err + dut0.u_sub_wr.sva0.fail_cnt;
        passed    = 0;
        foreach (err_cnt[i]) begin
            total_err += err_cnt[i];
            if (err_cnt[i] == 0) begin
                passed++;
            end
        end
        $display("Tests %0d, passed %0d, failed %0d, errors %0d",
                 tests.size(), passed, tests.size() - passed, total_err);
        if (total_err == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_clk_gen.sv ====
// Testbench clock of period 40 and active low reset held for two cycles
module tb_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);

    // Free running clock, 20 low and 20 high
    initial begin
        o_clk = 1'b0;
        forever begin
            #20 o_clk = ~o_clk;
        end
    end

    // Reset low for two rising edges, released on a falling edge
    initial begin
        o_rst_n = 1'b0;
        repeat (2) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule
